//--- source/sd_macros.svh
/*
 * Fixed dimensions of the two-channel CIC demodulator.
 * Included by the package and by every stage that sizes arrays or
 * saturation limits from the filter order or the output width.
 */
`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// Number of integrator and comb sections in each channel
`define SD_CIC_ORDER 3

// Width of the decimation ratio field, which stores the ratio minus one
`define SD_RATIO_BITS 8

// Input is a signed 2-bit value, and each section adds RATIO_BITS of growth
`define SD_ACC_WIDTH (2 + `SD_CIC_ORDER * `SD_RATIO_BITS)

// Width of the saturated output samples
`define SD_OUT_WIDTH 16

// Width of the arithmetic right-shift field applied before saturation
`define SD_SHIFT_BITS 5

`endif

//--- source/sd_pkg.sv
/*
 * Shared data types of the sigma-delta demodulator.
 * Stages refer to these by scoped name, for example sd_pkg::sd_acc_t.
 */
`include "sd_macros.svh"

package sd_pkg;

    // Accumulator word for integrators and combs, wraps on overflow
    typedef logic signed [`SD_ACC_WIDTH-1:0] sd_acc_t;

    // One saturated output sample per channel
    typedef logic signed [`SD_OUT_WIDTH-1:0] sd_sample_t;

    // Decimation ratio minus one, so 0 means every sample closes a period
    typedef logic [`SD_RATIO_BITS-1:0] sd_ratio_t;

    // Arithmetic right shift applied to the comb result
    typedef logic [`SD_SHIFT_BITS-1:0] sd_shift_t;

endpackage

//--- source/cic_link_if.sv
/*
 * Link from the integrator stage to the comb stage.
 * Carries both channel accumulators with a per-sample valid and the
 * marker of the sample that closes a decimation period.
 */
`timescale 1ns/1ps

interface cic_link_if;

    // Output of the last integrator of each channel
    sd_pkg::sd_acc_t acc_1;
    sd_pkg::sd_acc_t acc_2;

    // High on every cycle that carries a freshly integrated sample
    logic valid;

    // Qualified by valid, marks the closing sample of a decimation period
    logic last;

    modport source (
        output acc_1,
        output acc_2,
        output valid,
        output last
    );

    modport sink (
        input acc_1,
        input acc_2,
        input valid,
        input last
    );

endinterface

//--- source/sd_input_stage.sv
/*
 * Input stage of the demodulator.
 * Registers the two modulator bits and the enable level, then maps each
 * bit to a signed +1 or -1 for the integrators.
 */
`timescale 1ns/1ps

module sd_input_stage (
    input  logic              sd_clk,
    input  logic              rst,
    input  logic [1:0]        data_in,
    input  logic              enable,
    output logic signed [1:0] sample_1,
    output logic signed [1:0] sample_2,
    output logic              sample_valid
);

    // Raw modulator bits, captured once per sd_clk
    logic [1:0] bits_q;

    // Enable as seen on the same edge as the bits
    logic enable_q;

    always_ff @(posedge sd_clk) begin
        bits_q <= data_in;
    end

    always_ff @(posedge sd_clk) begin
        if (rst) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= enable;
        end
    end

    // A one maps to +1 and a zero maps to -1
    // While disabled the samples read as zero so nothing can leak downstream
    assign sample_1 = !enable_q ? 2'sd0 : (bits_q[0] ? 2'sd1 : -2'sd1);
    assign sample_2 = !enable_q ? 2'sd0 : (bits_q[1] ? 2'sd1 : -2'sd1);

    // Later stages only advance on this level
    assign sample_valid = enable_q;

endmodule

//--- source/cic_integrator_stage.sv
/*
 * Integrator half of the third-order CIC filter for both channels.
 * Each section is one register deep, so a sample reaches the link three
 * cycles after it enters. Also counts the decimation period.
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module cic_integrator_stage (
    input  logic              sd_clk,
    input  logic              rst,
    input  logic              clear,
    input  sd_pkg::sd_ratio_t ratio,
    input  logic signed [1:0] sample_1,
    input  logic signed [1:0] sample_2,
    input  logic              sample_valid,
    cic_link_if.source        link
);

    // Integrator registers, first index is the channel, second the section
    sd_pkg::sd_acc_t integ [2][`SD_CIC_ORDER];

    // Valid and last move along with the sample, one bit per section
    logic [`SD_CIC_ORDER-1:0] valid_pipe;
    logic [`SD_CIC_ORDER-1:0] last_pipe;

    // Position of the current sample within the decimation period
    sd_pkg::sd_ratio_t count;
    logic closing;

    // Input samples sign-extended to the accumulator width
    sd_pkg::sd_acc_t sample_ext [2];

    assign sample_ext[0] = sd_pkg::sd_acc_t'(sample_1);
    assign sample_ext[1] = sd_pkg::sd_acc_t'(sample_2);

    // The sample entering now is the last one of its period
    assign closing = sample_valid && (count == ratio);

    always_ff @(posedge sd_clk) begin
        if (rst || clear) begin
            count      <= '0;
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            // Counter holds while no valid sample arrives
            if (sample_valid) begin
                count <= closing ? '0 : count + 1'b1;
            end
            valid_pipe <= {valid_pipe[`SD_CIC_ORDER-2:0], sample_valid};
            last_pipe  <= {last_pipe[`SD_CIC_ORDER-2:0], closing};
        end
    end

    // Each section adds its predecessor's registered output when that output is fresh
    // Overflow wraps on purpose; the comb differences undo it exactly
    always_ff @(posedge sd_clk) begin
        if (rst || clear) begin
            for (int ch = 0; ch < 2; ch++) begin
                for (int k = 0; k < `SD_CIC_ORDER; k++) begin
                    integ[ch][k] <= '0;
                end
            end
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (sample_valid) begin
                    integ[ch][0] <= integ[ch][0] + sample_ext[ch];
                end
                for (int k = 1; k < `SD_CIC_ORDER; k++) begin
                    if (valid_pipe[k-1]) begin
                        integ[ch][k] <= integ[ch][k] + integ[ch][k-1];
                    end
                end
            end
        end
    end

    assign link.acc_1 = integ[0][`SD_CIC_ORDER-1];
    assign link.acc_2 = integ[1][`SD_CIC_ORDER-1];
    assign link.valid = valid_pipe[`SD_CIC_ORDER-1];
    assign link.last  = last_pipe[`SD_CIC_ORDER-1];

endmodule

//--- source/cic_comb_stage.sv
/*
 * Comb half of the CIC filter, running at the decimated rate.
 * Three differences, then an arithmetic shift and saturation to 16 bits.
 * out_valid pulses four cycles after the link marks a closing sample.
 */
`timescale 1ns/1ps
`include "sd_macros.svh"

module cic_comb_stage (
    input  logic               sd_clk,
    input  logic               rst,
    input  logic               clear,
    input  sd_pkg::sd_shift_t  shift,
    cic_link_if.sink           link,
    output logic               out_valid,
    output sd_pkg::sd_sample_t data_out_1,
    output sd_pkg::sd_sample_t data_out_2
);

    // Saturation limits of the output word
    localparam sd_pkg::sd_sample_t OUT_MAX = {1'b0, {(`SD_OUT_WIDTH-1){1'b1}}};
    localparam sd_pkg::sd_sample_t OUT_MIN = {1'b1, {(`SD_OUT_WIDTH-1){1'b0}}};

    // Comb results and the delayed input of each section, per channel
    sd_pkg::sd_acc_t comb_q  [2][`SD_CIC_ORDER];
    sd_pkg::sd_acc_t delay_q [2][`SD_CIC_ORDER];

    // Marks which comb section holds a fresh result
    logic [`SD_CIC_ORDER-1:0] stage_valid;

    // Decimated sample strobe taken from the link
    logic take;
    sd_pkg::sd_acc_t acc_in [2];

    // Clamp a shifted comb result into the 16-bit signed range
    function automatic sd_pkg::sd_sample_t saturate(input sd_pkg::sd_acc_t value);
        if (value > sd_pkg::sd_acc_t'(OUT_MAX)) begin
            return OUT_MAX;
        end else if (value < sd_pkg::sd_acc_t'(OUT_MIN)) begin
            return OUT_MIN;
        end
        return value[`SD_OUT_WIDTH-1:0];
    endfunction

    assign take      = link.valid && link.last;
    assign acc_in[0] = link.acc_1;
    assign acc_in[1] = link.acc_2;

    always_ff @(posedge sd_clk) begin
        if (rst || clear) begin
            stage_valid <= '0;
            out_valid   <= 1'b0;
        end else begin
            stage_valid <= {stage_valid[`SD_CIC_ORDER-2:0], take};
            out_valid   <= stage_valid[`SD_CIC_ORDER-1];
        end
    end

    // Every section subtracts its own previous input, updating only when fed
    always_ff @(posedge sd_clk) begin
        if (rst || clear) begin
            for (int ch = 0; ch < 2; ch++) begin
                for (int k = 0; k < `SD_CIC_ORDER; k++) begin
                    delay_q[ch][k] <= '0;
                end
            end
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (take) begin
                    delay_q[ch][0] <= acc_in[ch];
                end
                for (int k = 1; k < `SD_CIC_ORDER; k++) begin
                    if (stage_valid[k-1]) begin
                        delay_q[ch][k] <= comb_q[ch][k-1];
                    end
                end
            end
        end
    end

    // The differences themselves, wrapping just like the integrators
    always_ff @(posedge sd_clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (take) begin
                comb_q[ch][0] <= acc_in[ch] - delay_q[ch][0];
            end
            for (int k = 1; k < `SD_CIC_ORDER; k++) begin
                if (stage_valid[k-1]) begin
                    comb_q[ch][k] <= comb_q[ch][k-1] - delay_q[ch][k];
                end
            end
        end
    end

    // Outputs hold their value until the next decimated result
    always_ff @(posedge sd_clk) begin
        if (stage_valid[`SD_CIC_ORDER-1]) begin
            data_out_1 <= saturate(comb_q[0][`SD_CIC_ORDER-1] >>> shift);
            data_out_2 <= saturate(comb_q[1][`SD_CIC_ORDER-1] >>> shift);
        end
    end

endmodule

//--- source/sd_processor.sv
/*
 * Top level of the two-channel sigma-delta demodulator.
 * Holds the decimation ratio and output shift, written by cfg_write,
 * and chains the input, integrator and comb stages.
 */
`timescale 1ns/1ps

module sd_processor (
    input  logic               sd_clk,
    input  logic               rst,
    input  logic [1:0]         data_in,
    input  logic               enable,
    input  logic               cfg_write,
    input  sd_pkg::sd_ratio_t  cfg_ratio,
    input  sd_pkg::sd_shift_t  cfg_shift,
    output logic               out_valid,
    output sd_pkg::sd_sample_t data_out_1,
    output sd_pkg::sd_sample_t data_out_2
);

    // Power-up configuration is a ratio of 64 and a shift of 2
    localparam sd_pkg::sd_ratio_t RATIO_RESET = 8'd63;
    localparam sd_pkg::sd_shift_t SHIFT_RESET = 5'd2;

    sd_pkg::sd_ratio_t ratio_q;
    sd_pkg::sd_shift_t shift_q;

    // Mapped samples between the input stage and the integrators
    logic signed [1:0] sample_1;
    logic signed [1:0] sample_2;
    logic              sample_valid;

    cic_link_if link ();

    always_ff @(posedge sd_clk) begin
        if (rst) begin
            ratio_q <= RATIO_RESET;
            shift_q <= SHIFT_RESET;
        end else if (cfg_write) begin
            ratio_q <= cfg_ratio;
            shift_q <= cfg_shift;
        end
    end

    sd_input_stage u_input (
        .sd_clk       (sd_clk),
        .rst          (rst),
        .data_in      (data_in),
        .enable       (enable),
        .sample_1     (sample_1),
        .sample_2     (sample_2),
        .sample_valid (sample_valid)
    );

    // A configuration write restarts the filter in the same cycle
    cic_integrator_stage u_integrator (
        .sd_clk       (sd_clk),
        .rst          (rst),
        .clear        (cfg_write),
        .ratio        (ratio_q),
        .sample_1     (sample_1),
        .sample_2     (sample_2),
        .sample_valid (sample_valid),
        .link         (link.source)
    );

    cic_comb_stage u_comb (
        .sd_clk     (sd_clk),
        .rst        (rst),
        .clear      (cfg_write),
        .shift      (shift_q),
        .link       (link.sink),
        .out_valid  (out_valid),
        .data_out_1 (data_out_1),
        .data_out_2 (data_out_2)
    );

endmodule

//--- tb/sd_clock_gen.sv
/*
 * Clock and reset source for the demodulator testbench.
 * Drives sd_clk with an 8 ns period and holds rst high for 3 cycles.
 */
`timescale 1ns/1ps

module sd_clock_gen (
    output logic sd_clk,
    output logic rst
);

    initial begin
        sd_clk = 1'b0;
        rst    = 1'b1;
        repeat (3) @(posedge sd_clk);
        rst <= 1'b0;
    end

    // Half of the 8 ns period
    always #4 sd_clk = ~sd_clk;

endmodule

//--- tb/sd_processor_tb.sv
/*
 * Testbench for the two-channel sigma-delta demodulator.
 * Streams constant, alternating and gapped bit patterns, predicts every
 * decimated sample from the CIC impulse response and checks with assertions.
 */
`timescale 1ns/1ps

module sd_processor_tb;

    // Outputs awaited per test, with the ratio each test runs at in the watchdog sum
    localparam int T1_OUT = 5;
    localparam int T2_OUT = 8;
    localparam int T3_OUT = 10;
    localparam int T4_OUT = 6;
    localparam int T5_OUT = 10;
    localparam int T6_OUT = 8;
    localparam int GAP_LEN = 37;
    localparam int WATCH_CYCLES = T1_OUT * 64 + T2_OUT * 64 + T3_OUT * 16 + T4_OUT * 64
        + T5_OUT * 32 + T6_OUT * 64 + GAP_LEN;
    // Input stage, three integrators, three combs and the output register
    localparam int PIPE_LATENCY = 8;
    localparam int HIST_DEPTH = 4096;
    localparam int CONSTANT = 0;
    localparam int ALTERNATING = 1;

    logic               sd_clk;
    logic               rst;
    logic [1:0]         data_in;
    logic               enable;
    logic               cfg_write;
    sd_pkg::sd_ratio_t  cfg_ratio;
    sd_pkg::sd_shift_t  cfg_shift;
    logic               out_valid;
    sd_pkg::sd_sample_t data_out_1;
    sd_pkg::sd_sample_t data_out_2;

    // Reference model state
    // The history holds the mapped samples since the last clear
    int resp [3 * 256];
    int hist [2][HIST_DEPTH];
    int hist_len = 0;
    int out_count = 0;
    int checked = 0;
    int cur_ratio = 64;
    int cur_shift = 2;
    int exp_1 = 0;
    int exp_2 = 0;
    logic [PIPE_LATENCY-1:0] closing_hist = '0;
    logic closing_tb;

    // Bookkeeping for the per-test report lines
    int fail_count = 0;
    int fails_mark = 0;
    int checked_mark = 0;
    int tests_run = 0;
    int failed_tests = 0;
    string test_name = "startup";
    bit alt_phase = 1'b0;

    sd_clock_gen u_clock (
        .sd_clk (sd_clk),
        .rst    (rst)
    );

    sd_processor DUT (
        .sd_clk     (sd_clk),
        .rst        (rst),
        .data_in    (data_in),
        .enable     (enable),
        .cfg_write  (cfg_write),
        .cfg_ratio  (cfg_ratio),
        .cfg_shift  (cfg_shift),
        .out_valid  (out_valid),
        .data_out_1 (data_out_1),
        .data_out_2 (data_out_2)
    );

    // The sample the DUT takes on this edge is the ratio-th of its period
    assign closing_tb = enable && ((hist_len + 1) % cur_ratio == 0);

    // Weights of three cascaded boxcars of length R
    task automatic load_response(input int r);
        for (int j = 0; j < 3 * 256; j++) begin
            resp[j] = 0;
        end
        for (int a = 0; a < r; a++) begin
            for (int b = 0; b < r; b++) begin
                for (int c = 0; c < r; c++) begin
                    resp[a + b + c] += 1;
                end
            end
        end
    endtask

    // Convolution at the k-th closing sample, then shift and clamp to 16 bits
    function automatic int model_output(input int ch, input int k);
        int sum;
        int idx;
        sum = 0;
        for (int j = 0; j <= 3 * cur_ratio - 3; j++) begin
            idx = k * cur_ratio - 1 - j;
            if (idx >= 0 && idx < hist_len) begin
                sum += resp[j] * hist[ch][idx];
            end
        end
        sum = sum >>> cur_shift;
        if (sum > 32767) begin
            return 32767;
        end
        if (sum < -32768) begin
            return -32768;
        end
        return sum;
    endfunction

    // Records what the DUT sampled on each edge
    // The soft clear wipes it all
    always @(posedge sd_clk) begin
        if (rst || cfg_write) begin
            hist_len     <= 0;
            out_count    <= 0;
            closing_hist <= '0;
        end else begin
            closing_hist <= {closing_hist[PIPE_LATENCY-2:0], closing_tb};
            if (enable && hist_len < HIST_DEPTH) begin
                hist[0][hist_len] <= data_in[0] ? 1 : -1;
                hist[1][hist_len] <= data_in[1] ? 1 : -1;
                hist_len <= hist_len + 1;
            end
            if (out_valid) begin
                out_count <= out_count + 1;
                if (out_count >= 3) begin
                    checked <= checked + 1;
                end
            end
        end
    end

    // Expected values settle half a cycle before the edge that checks them
    always @(negedge sd_clk) begin
        if (out_valid) begin
            exp_1 <= model_output(0, out_count + 1);
            exp_2 <= model_output(1, out_count + 1);
        end
    end

    // A pulse is due exactly eight edges after each closing sample and at no other time
    timing_check: assert property (@(posedge sd_clk) disable iff (rst)
        out_valid == closing_hist[PIPE_LATENCY-1])
    else begin
        $display("Test %s: out_valid was %0b on a cycle where the decimation timing needs %0b",
            test_name, out_valid, closing_hist[PIPE_LATENCY-1]);
        fail_count++;
    end

    // The first three outputs after a clear carry the filter transient
    ch1_value_check: assert property (@(posedge sd_clk) disable iff (rst)
        (out_valid && out_count >= 3) |-> int'(data_out_1) == exp_1)
    else begin
        $display("[FAIL] %s: data_out_1 expected %0d, actual %0d", test_name, exp_1, data_out_1);
        fail_count++;
    end

    ch2_value_check: assert property (@(posedge sd_clk) disable iff (rst)
        (out_valid && out_count >= 3) |-> int'(data_out_2) == exp_2)
    else begin
        $display("[FAIL] %s: data_out_2 expected %0d, actual %0d", test_name, exp_2, data_out_2);
        fail_count++;
    end

    // Writes a new ratio and shift with the input idle on both sides
    task automatic configure(input int ratio, input int shift);
        @(posedge sd_clk);
        enable <= 1'b0;
        // Any result still in the pipeline comes out before the clear
        repeat (PIPE_LATENCY + 2) @(posedge sd_clk);
        cfg_write <= 1'b1;
        cfg_ratio <= sd_pkg::sd_ratio_t'(ratio - 1);
        cfg_shift <= sd_pkg::sd_shift_t'(shift);
        @(posedge sd_clk);
        cfg_write <= 1'b0;
        cur_ratio = ratio;
        cur_shift = shift;
        load_response(ratio);
        // The output count restarts on the clearing edge and is zero from the next one
        @(posedge sd_clk);
    endtask

    // Channel 1 gets ones and channel 2 zeros, or both alternate
    task automatic feed(input int mode, input int outputs, input int max_cycles);
        int n;
        n = 0;
        while (out_count < outputs && n < max_cycles) begin
            @(posedge sd_clk);
            enable  <= 1'b1;
            data_in <= (mode == CONSTANT) ? 2'b01 : {alt_phase, alt_phase};
            alt_phase = ~alt_phase;
            n++;
        end
    endtask

    task automatic pause_input(input int cycles);
        repeat (cycles) begin
            @(posedge sd_clk);
            enable <= 1'b0;
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        fails_mark   = fail_count;
        checked_mark = checked;
    endtask

    task automatic finish_test();
        tests_run++;
        if (fail_count != fails_mark) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d outputs checked, %0d failed checks", tests_run, test_name,
            checked - checked_mark, fail_count - fails_mark);
    endtask

    initial begin
        int seed_dummy;
        int rand_ratio;
        data_in   = 2'b00;
        enable    = 1'b0;
        cfg_write = 1'b0;
        cfg_ratio = 8'd63;
        cfg_shift = 5'd2;
        seed_dummy = $urandom(94);
        load_response(64);
        wait (rst === 1'b0);

        // Idle after reset, then the power-up ratio of 64 and shift of 2
        start_test("reset_idle");
        repeat (20) @(posedge sd_clk);
        feed(CONSTANT, T1_OUT, 1 << 20);
        finish_test();

        start_test("constant_shift6");
        configure(64, 6);
        feed(CONSTANT, T2_OUT, 1 << 20);
        finish_test();

        start_test("alternating");
        configure(16, 0);
        feed(ALTERNATING, T3_OUT, 1 << 20);
        finish_test();

        start_test("saturation");
        configure(64, 0);
        feed(CONSTANT, T4_OUT, 1 << 20);
        finish_test();

        start_test("random_ratio");
        rand_ratio = 8 + int'($urandom % 25);
        configure(rand_ratio, 0);
        feed(CONSTANT, T5_OUT, 1 << 20);
        finish_test();

        // Gap lands mid-period, so the next pulse slips by its length
        start_test("enable_gap");
        configure(64, 6);
        feed(CONSTANT, 4, 1 << 20);
        feed(CONSTANT, 1 << 20, 20);
        pause_input(GAP_LEN);
        feed(CONSTANT, T6_OUT, 1 << 20);
        finish_test();

        $display("%0d tests run, %0d tests failed, %0d checks failed, %0d outputs checked",
            tests_run, failed_tests, fail_count, checked);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Twice the total streaming time of all tests, plus room for the idle cycles
    initial begin
        #(WATCH_CYCLES * 8 * 2 + 2000);
        $display("Watchdog expired in test %s before all outputs arrived", test_name);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/sd_pkg.sv
source/cic_link_if.sv
source/sd_input_stage.sv
source/cic_integrator_stage.sv
source/cic_comb_stage.sv
source/sd_processor.sv
tb/sd_clock_gen.sv
tb/sd_processor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the demodulator testbench with Verilator and runs it once.
# The exit status is zero only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f project.f \
    --top-module sd_processor_tb -o sd_processor_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sd_processor_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
